// File: sources.f
source/video_pkg.sv
source/bus_pkg.sv
source/palette_ram.sv
source/prio_prom.sv
source/apb_cpu_port.sv
source/color_mixer.sv
source/video_top.sv
testbench/tb_video_top.sv

// File: Makefile
# Verilator simulation of the colour mixing stage

VERILATOR ?= verilator
TOP       ?= tb_video_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_video_top.sv
// testbench with clock, reset, pixel enable, xorshift, palette and PROM model, checks, directed tests
module tb_video_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int SWEEP_PIXELS  = 200;
    // run length estimate for the watchdog
    localparam int N_XFERS       = 1400;   // fill plus directed transfers
    localparam int XFER_CYCLES   = 5;      // palette transfer with idle cycle
    localparam int N_PIX         = 230;
    localparam int PIX_CYCLES    = 10;     // pipeline fill plus wait for pxl_cen
    localparam int MARGIN_CYCLES = 500;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_XFERS * XFER_CYCLES
                                   + N_PIX * PIX_CYCLES + MARGIN_CYCLES;
    localparam logic [11:0] BLUE_OFS = 12'(1) << bus_pkg::PAL_BANK_BIT;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic [6:0]  char_pxl;
    logic [7:0]  obj_pxl;
    logic [7:0]  scr_pxl;
    logic        hblank_n;
    logic        vblank_n;
    logic        pxl_cen = 1'b0;
    logic [2:0]  layer_en;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;

    logic [1:0]  cen_cnt = 2'd0;
    logic [31:0] rng_state = 32'haab41cb4;
    // reference copies filled only by our own bus writes
    logic [7:0]  model_gr [0:511];         // green in the upper nibble and red below
    logic [3:0]  model_b [0:511];
    logic [1:0]  model_prom [0:255];

    video_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pixel clock enable on every fourth clock
    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        pxl_cen <= cen_cnt == 2'd3;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // transparency rule gives the PROM address
    function automatic logic [7:0] prio_index(input logic [6:0] c, input logic [7:0] o,
                                              input logic [7:0] s, input logic [2:0] en);
        logic       char_t;
        logic       obj_t;
        logic [7:0] sg;
        char_t = !en[video_pkg::EN_CHAR] || c[3:0] == 4'd0;
        obj_t  = !en[video_pkg::EN_OBJ] || o[3:0] == 4'd0;
        sg     = en[video_pkg::EN_SCR] ? s : 8'd0;   // disabled scroll reads as zero
        return {sg[7], o[7], obj_t, char_t, sg[3:0]};
    endfunction

    // {red, green, blue} of the winning layer from the model
    function automatic logic [11:0] expected_rgb(input logic [6:0] c, input logic [7:0] o,
                                                 input logic [7:0] s, input logic [2:0] en);
        logic [7:0]            sg;
        video_pkg::pal_index_u idx;
        sg = en[video_pkg::EN_SCR] ? s : 8'd0;
        idx = '0;
        if (model_prom[prio_index(c, o, s, en)] == video_pkg::LAYER_OBJ) begin
            idx.pxl.bank  = video_pkg::BANK_OBJ;
            idx.pxl.color = o[6:0];
        end else if (model_prom[prio_index(c, o, s, en)] == video_pkg::LAYER_SCR) begin
            idx.pxl.bank  = video_pkg::BANK_SCR;
            idx.pxl.color = sg[6:0];
        end else begin
            idx.pxl.bank  = video_pkg::BANK_CHAR;   // codes 0 and 1
            idx.pxl.color = c;
        end
        return {model_gr[idx.cpu][3:0], model_gr[idx.cpu][7:4], model_b[idx.cpu]};
    endfunction

    // one APB transfer with protocol checks by region
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [7:0] wd,
                            output logic [7:0] rd, output logic err);
        logic is_pal;
        logic is_prom;
        logic exp_err;
        int   cycles;
        is_pal  = (addr - bus_pkg::PAL_BASE) < bus_pkg::PAL_SIZE;
        is_prom = (addr - bus_pkg::PROM_BASE) < bus_pkg::PROM_SIZE;
        exp_err = (is_prom && !wr) || (!is_pal && !is_prom);   // prom read or unmapped
        @(negedge clk);
        check_value("pready", pready, 0);  // idle before setup
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wd;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 1;
        while (!pready) begin
            if (cycles > 2 * bus_pkg::PAL_WAIT) begin
                abort_run("APB transfer never completed, pready stayed low");
            end
            @(negedge clk);
            cycles++;
        end
        rd  = prdata;
        err = pslverr;
        check_value("access cycles", cycles, is_pal ? bus_pkg::PAL_WAIT : 1);
        check_value("pslverr", err, exp_err);
        if (!is_pal) begin
            check_value("prdata", rd, 0);  // nothing to return outside the palette
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [7:0] data);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b1, addr, data, rd, err);
    endtask

    task automatic read_check(input string name, input logic [11:0] addr, input logic [7:0] exp);
        logic [7:0] rd;
        logic       err;
        apb_xfer(1'b0, addr, 8'h00, rd, err);
        check_value(name, rd, exp);
    endtask

    task automatic write_gr(input logic [8:0] entry, input logic [7:0] data);
        apb_write(bus_pkg::PAL_BASE | {3'b000, entry}, data);
        model_gr[entry] = data;
    endtask

    task automatic write_blue(input logic [8:0] entry, input logic [7:0] data);
        apb_write(bus_pkg::PAL_BASE | BLUE_OFS | {3'b000, entry}, data);
        model_b[entry] = data[3:0];          // only the low nibble is stored
    endtask

    task automatic write_prom(input logic [7:0] addr, input logic [1:0] code);
        apb_write(bus_pkg::PROM_BASE | {4'h0, addr}, {6'd0, code});
        model_prom[addr] = code;
    endtask

    // hold a pixel set through the pipeline and a pxl_cen before comparing RGB
    task automatic pixel_check(input logic [6:0] c, input logic [7:0] o, input logic [7:0] s,
                               input logic [2:0] en, input logic hb, input logic vb);
        logic [11:0] exp_rgb;
        @(negedge clk);
        char_pxl = c;
        obj_pxl  = o;
        scr_pxl  = s;
        layer_en = en;
        hblank_n = hb;
        vblank_n = vb;
        repeat (3) @(posedge clk);           // prom, address register, ram read
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);     // RGB load
        @(negedge clk);
        exp_rgb = (hb && vb) ? expected_rgb(c, o, s, en) : 12'h000;
        check_value("rgb", {red, green, blue}, exp_rgb);
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        for (int i = 0; i < 512; i++) begin
            r = next_rand();
            write_gr(i[8:0], r[7:0]);
            write_blue(i[8:0], r[15:8]);
        end
        for (int i = 0; i < 256; i++) begin
            r = next_rand();
            write_prom(i[7:0], r[1:0]);
        end
    endtask

    task automatic palette_readback();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            write_gr(r[8:0], r[23:16]);
            read_check("palette gr", {3'b000, r[8:0]}, r[23:16]);
            write_blue(r[8:0], r[31:24]);
            read_check("palette blue", BLUE_OFS | {3'b000, r[8:0]}, {4'hF, r[27:24]});
        end
    endtask

    task automatic priority_selection();
        logic [6:0] c;
        logic [7:0] o;
        logic [7:0] s;
        for (int p = 0; p < 2; p++) begin
            c = (p == 0) ? 7'h15 : 7'h3A;
            o = (p == 0) ? 8'h23 : 8'hA3;    // second set has the high bits set
            s = (p == 0) ? 8'h47 : 8'hC5;
            for (int code = 0; code < 4; code++) begin
                write_prom(prio_index(c, o, s, 3'b111), code[1:0]);
                pixel_check(c, o, s, 3'b111, 1'b1, 1'b1);
            end
        end
    endtask

    task automatic layer_transparency();
        logic [6:0] c;
        logic [7:0] o;
        logic [2:0] en;
        logic [7:0] base_pa;
        for (int v = 0; v < 5; v++) begin
            c  = 7'h2B;
            o  = 8'h5C;
            en = 3'b111;
            case (v)
                0: c[3:0] = 4'd0;
                1: o[3:0] = 4'd0;
                2: en[video_pkg::EN_CHAR] = 1'b0;
                3: en[video_pkg::EN_OBJ] = 1'b0;
                default: en[video_pkg::EN_SCR] = 1'b0;
            endcase
            base_pa = prio_index(7'h2B, 8'h5C, 8'h96, 3'b111);
            write_prom(base_pa, video_pkg::LAYER_OBJ);
            // variant entry picks something else than the opaque set
            write_prom(prio_index(c, o, 8'h96, en),
                       (v == 4) ? video_pkg::LAYER_CHAR : video_pkg::LAYER_SCR);
            pixel_check(7'h2B, 8'h5C, 8'h96, 3'b111, 1'b1, 1'b1);
            pixel_check(c, o, 8'h96, en, 1'b1, 1'b1);
        end
    endtask

    task automatic blanking_output();
        pixel_check(7'h19, 8'h37, 8'h5E, 3'b111, 1'b0, 1'b1);
        pixel_check(7'h19, 8'h37, 8'h5E, 3'b111, 1'b1, 1'b0);
        pixel_check(7'h19, 8'h37, 8'h5E, 3'b111, 1'b0, 1'b0);
        pixel_check(7'h19, 8'h37, 8'h5E, 3'b111, 1'b1, 1'b1);   // back to colour
    endtask

    task automatic bus_error_response();
        logic [31:0] r;
        logic [8:0]  e;
        logic [7:0]  rd;
        logic        err;
        r = next_rand();
        e = r[8:0];
        write_gr(e, r[23:16]);
        write_blue(e, r[31:24]);
        apb_xfer(1'b0, bus_pkg::PROM_BASE | {4'h0, e[7:0]}, 8'h00, rd, err);  // prom read
        apb_xfer(1'b1, 12'h800 | {3'b000, e}, ~r[23:16], rd, err);
        apb_xfer(1'b0, 12'hC00 | {3'b000, e}, 8'h00, rd, err);
        apb_xfer(1'b1, 12'h500 | {4'h0, e[7:0]}, ~r[31:24], rd, err);  // just past the prom
        // palette keeps its contents
        read_check("palette gr", {3'b000, e}, r[23:16]);
        read_check("palette blue", BLUE_OFS | {3'b000, e}, {4'hF, r[27:24]});
    endtask

    task automatic random_pixel_sweep();
        logic [31:0] r;
        for (int i = 0; i < SWEEP_PIXELS; i++) begin
            r = next_rand();
            pixel_check(r[6:0], r[14:7], r[22:15], r[25:23], 1'b1, 1'b1);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        char_pxl = '0;
        obj_pxl  = '0;
        scr_pxl  = '0;
        hblank_n = 1'b1;
        vblank_n = 1'b1;
        layer_en = 3'b111;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        fill_memories();
        palette_readback();
        priority_selection();
        layer_transparency();
        blanking_output();
        bus_error_response();
        random_pixel_sweep();
        $display("Testbench passed");
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout, run still busy after %0d cycles", WATCHDOG_CYCLES));
    end

endmodule

// File: source/video_top.sv
// video_top: APB slave port and colour mixer of the video board
module video_top (
    input  logic                              clk,
    input  logic                              rst_n,
    // APB slave
    input  logic [bus_pkg::APB_AW-1:0]        paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [7:0]                        pwdata,
    output logic [7:0]                        prdata,
    output logic                              pready,
    output logic                              pslverr,
    // pixel side
    input  logic [video_pkg::CHAR_W-1:0]      char_pxl,
    input  logic [video_pkg::OBJ_W-1:0]       obj_pxl,
    input  logic [video_pkg::SCR_W-1:0]       scr_pxl,
    input  logic                              hblank_n,
    input  logic                              vblank_n,
    input  logic                              pxl_cen,
    input  logic [video_pkg::LAYER_EN_W-1:0]  layer_en,
    output logic [video_pkg::RGB_W-1:0]       red,
    output logic [video_pkg::RGB_W-1:0]       green,
    output logic [video_pkg::RGB_W-1:0]       blue
);

    // cpu side palette cycle
    logic                          pal_cs;
    logic                          pal_wr;
    logic [bus_pkg::PAL_BANK_BIT:0] pal_addr;
    logic [7:0]                    pal_wdata;
    logic [7:0]                    pal_rdata;
    // priority PROM programming
    logic                          prom_we;
    logic [video_pkg::PRIO_AW-1:0] prom_addr;
    logic [video_pkg::PRIO_DW-1:0] prom_data;

    apb_cpu_port apb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pal_cs    (pal_cs),
        .pal_wr    (pal_wr),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata),
        .pal_rdata (pal_rdata),
        .prom_we   (prom_we),
        .prom_addr (prom_addr),
        .prom_data (prom_data)
    );

    color_mixer mixer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .hblank_n  (hblank_n),
        .vblank_n  (vblank_n),
        .char_pxl  (char_pxl),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .layer_en  (layer_en),
        .pal_cs    (pal_cs),
        .pal_wr    (pal_wr),
        .pal_addr  (pal_addr),
        .pal_wdata (pal_wdata),
        .pal_rdata (pal_rdata),
        .prom_we   (prom_we),
        .prom_addr (prom_addr),
        .prom_data (prom_data),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// File: source/color_mixer.sv
// color_mixer: layer transparency, priority lookup, palette addressing, palette readback, RGB out
module color_mixer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              pxl_cen,
    input  logic                              hblank_n,
    input  logic                              vblank_n,
    input  logic [video_pkg::CHAR_W-1:0]      char_pxl,
    input  logic [video_pkg::OBJ_W-1:0]       obj_pxl,
    input  logic [video_pkg::SCR_W-1:0]       scr_pxl,
    input  logic [video_pkg::LAYER_EN_W-1:0]  layer_en,
    input  logic                              pal_cs,
    input  logic                              pal_wr,
    input  logic [bus_pkg::PAL_BANK_BIT:0]    pal_addr,
    input  logic [7:0]                        pal_wdata,
    output logic [7:0]                        pal_rdata,
    input  logic                              prom_we,
    input  logic [video_pkg::PRIO_AW-1:0]     prom_addr,
    input  logic [video_pkg::PRIO_DW-1:0]     prom_data,
    output logic [video_pkg::RGB_W-1:0]       red,
    output logic [video_pkg::RGB_W-1:0]       green,
    output logic [video_pkg::RGB_W-1:0]       blue
);

    localparam int RW = video_pkg::RGB_W;
    localparam int DW = video_pkg::PAL_DW;
    localparam int CW = video_pkg::CHAR_W;

    logic                          char_blank;
    logic                          obj_blank;
    logic [video_pkg::SCR_W-1:0]   scr_gated;
    logic [video_pkg::PRIO_AW-1:0] prio_addr;
    logic [video_pkg::PRIO_DW-1:0] prio;
    video_pkg::pal_index_u         pal_idx_next;
    video_pkg::pal_index_u         pal_idx;
    logic                          pal_gr_we;
    logic                          pal_b_we;
    logic [DW-1:0]                 pal_din;
    logic [DW-1:0]                 pal_b_din;
    logic [DW-1:0]                 pal_gr_q;
    logic [DW-1:0]                 pal_b_q;
    logic                          visible;

    // transparency, colour 0 of a layer shows what is behind
    assign char_blank = !layer_en[video_pkg::EN_CHAR] || char_pxl[3:0] == 4'd0;
    assign obj_blank  = !layer_en[video_pkg::EN_OBJ] || obj_pxl[3:0] == 4'd0;
    assign scr_gated  = scr_pxl & {video_pkg::SCR_W{layer_en[video_pkg::EN_SCR]}};

    // priority rule address
    assign prio_addr = {scr_gated[video_pkg::SCR_W-1], obj_pxl[video_pkg::OBJ_W-1],
                        obj_blank, char_blank, scr_gated[3:0]};

    prio_prom prio_i (
        .clk     (clk),
        .rd_addr (prio_addr),
        .rdata   (prio),
        .wr_addr (prom_addr),
        .wdata   (prom_data),
        .we      (prom_we)
    );

    // palette address, the cpu wins over the pixel path
    always_comb begin
        pal_idx_next = '0;
        if (pal_cs) begin
            pal_idx_next.cpu = pal_addr[video_pkg::PAL_AW-1:0];
        end else begin
            case (video_pkg::layer_e'(prio))
                video_pkg::LAYER_OBJ: begin
                    pal_idx_next.pxl.bank  = video_pkg::BANK_OBJ;
                    pal_idx_next.pxl.color = obj_pxl[CW-1:0];   // bit 7 only steers priority
                end
                video_pkg::LAYER_SCR: begin
                    pal_idx_next.pxl.bank  = video_pkg::BANK_SCR;
                    pal_idx_next.pxl.color = scr_gated[CW-1:0];
                end
                video_pkg::LAYER_CHAR, video_pkg::LAYER_CHAR_ALT: begin
                    pal_idx_next.pxl.bank  = video_pkg::BANK_CHAR;
                    pal_idx_next.pxl.color = char_pxl;
                end
            endcase
        end
    end

    // bank write enables
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pal_gr_we <= 1'b0;
            pal_b_we  <= 1'b0;
        end else begin
            pal_gr_we <= pal_cs && pal_wr && !pal_addr[bus_pkg::PAL_BANK_BIT];
            pal_b_we  <= pal_cs && pal_wr &&  pal_addr[bus_pkg::PAL_BANK_BIT];
        end
    end

    always_ff @(posedge clk) begin
        pal_idx   <= pal_idx_next;
        pal_din   <= pal_wdata;
        // blue reads back with the upper nibble set
        pal_rdata <= pal_addr[bus_pkg::PAL_BANK_BIT] ? (pal_b_q | 8'hF0) : pal_gr_q;
    end

    assign pal_b_din = {{RW{1'b0}}, pal_din[RW-1:0]};   // blue in the low nibble

    palette_ram pal_gr_i (
        .clk   (clk),
        .addr  (pal_idx.cpu),
        .wdata (pal_din),
        .we    (pal_gr_we),
        .rdata (pal_gr_q)
    );

    palette_ram pal_b_i (
        .clk   (clk),
        .addr  (pal_idx.cpu),
        .wdata (pal_b_din),
        .we    (pal_b_we),
        .rdata (pal_b_q)
    );

    assign visible = hblank_n && vblank_n;

    // RGB on the pixel clock enable, black while blanked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            red   <= visible ? pal_gr_q[RW-1:0]  : '0;
            green <= visible ? pal_gr_q[DW-1:RW] : '0;
            blue  <= visible ? pal_b_q[RW-1:0]   : '0;
        end
    end

    // bus port only writes inside a palette cycle
    a_wr_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
        pal_wr |-> pal_cs)
        else $error("palette write without chip select");

    // blanking reaches the pins at the next load
    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && !visible |=> red == '0 && green == '0 && blue == '0)
        else $error("colour out during blanking");

endmodule

// File: source/apb_cpu_port.sv
// apb_cpu_port: APB slave with region decode, palette wait counter, PROM write strobe, pslverr
module apb_cpu_port (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [bus_pkg::APB_AW-1:0]        paddr,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [7:0]                        pwdata,
    output logic [7:0]                        prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              pal_cs,
    output logic                              pal_wr,
    output logic [bus_pkg::PAL_BANK_BIT:0]    pal_addr,
    output logic [7:0]                        pal_wdata,
    input  logic [7:0]                        pal_rdata,
    output logic                              prom_we,
    output logic [video_pkg::PRIO_AW-1:0]     prom_addr,
    output logic [video_pkg::PRIO_DW-1:0]     prom_data
);

    logic                          pal_hit;
    logic                          prom_hit;
    logic                          err_hit;
    logic                          setup;
    logic                          access;
    logic [bus_pkg::PAL_CNT_W-1:0] wait_cnt;  // access cycles done so far

    // region decode
    assign pal_hit  = (paddr & bus_pkg::PAL_MASK) == bus_pkg::PAL_BASE;
    assign prom_hit = (paddr & bus_pkg::PROM_MASK) == bus_pkg::PROM_BASE;
    assign err_hit  = !pal_hit && !(prom_hit && pwrite); // prom reads are errors too

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // palette strobe from setup until the last access cycle
    assign pal_cs    = psel && pal_hit && !pready;
    assign pal_wr    = pal_cs && pwrite;
    assign pal_addr  = paddr[bus_pkg::PAL_BANK_BIT:0]; // bank bit plus entry
    assign pal_wdata = pwdata;

    // prom payload straight from the bus, valid while prom_we is high
    assign prom_addr = paddr[video_pkg::PRIO_AW-1:0];
    assign prom_data = pwdata[video_pkg::PRIO_DW-1:0];

    // read data only on a palette completion
    assign prdata = (pready && pal_hit) ? pal_rdata : 8'h00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            prom_we  <= 1'b0;
        end else begin
            // palette waits out its access phase
            wait_cnt <= (access && pal_hit && !pready) ? wait_cnt + 1'b1 : '0;
            pready   <= (setup && !pal_hit) ||
                        (access && pal_hit && !pready && wait_cnt == bus_pkg::PAL_LAST_CNT);
            pslverr  <= setup && err_hit;          // lines up with the one cycle pready
            prom_we  <= setup && pwrite && prom_hit; // high in the first access cycle
        end
    end

    // completion only inside an access phase
    a_pready_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable)
        else $error("pready outside access phase");

    // single clock prom strobe per transfer
    a_prom_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |=> !prom_we)
        else $error("prom_we longer than one clock");

endmodule

// File: source/prio_prom.sv
// prio_prom: 256 x 2 priority lookup with pixel read port and programming write port
module prio_prom (
    input  logic                          clk,
    input  logic [video_pkg::PRIO_AW-1:0] rd_addr,
    output logic [video_pkg::PRIO_DW-1:0] rdata,
    input  logic [video_pkg::PRIO_AW-1:0] wr_addr,
    input  logic [video_pkg::PRIO_DW-1:0] wdata,
    input  logic                          we
);

    // layer code per transparency and palette bit combination
    logic [video_pkg::PRIO_DW-1:0] mem [0:(1 << video_pkg::PRIO_AW)-1];

    // loaded once by the cpu at start-up
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wdata;
        end
    end

    // pixel side lookup, one clock
    always_ff @(posedge clk) begin
        rdata <= mem[rd_addr];
    end

endmodule

// File: source/palette_ram.sv
// palette_ram: 512 entry palette bank, synchronous write and registered read
module palette_ram (
    input  logic                         clk,
    input  logic [video_pkg::PAL_AW-1:0] addr,
    input  logic [video_pkg::PAL_DW-1:0] wdata,
    input  logic                         we,
    output logic [video_pkg::PAL_DW-1:0] rdata
);

    // one byte per entry, blue bank keeps its upper nibble clear
    logic [video_pkg::PAL_DW-1:0] mem [0:(1 << video_pkg::PAL_AW)-1];

    // write and read share the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;             // cpu write, pixel path idle
        end
        rdata <= mem[addr];                 // old data on a write cycle
    end

endmodule

// File: source/bus_pkg.sv
// bus map: APB address width, palette and PROM regions, decode masks, palette wait states
package bus_pkg;

    localparam int APB_AW = 12;

    // palette region, blue bank on bit 9, entry on bits 8..0
    localparam logic [APB_AW-1:0] PAL_BASE     = 12'h000;
    localparam logic [APB_AW-1:0] PAL_SIZE     = 12'h400;
    localparam logic [APB_AW-1:0] PAL_MASK     = ~(PAL_SIZE - 12'h001);
    localparam int                PAL_BANK_BIT = 9;

    // priority PROM region, write only from the bus
    localparam logic [APB_AW-1:0] PROM_BASE = 12'h400;
    localparam logic [APB_AW-1:0] PROM_SIZE = 12'h100;
    localparam logic [APB_AW-1:0] PROM_MASK = ~(PROM_SIZE - 12'h001);

    // palette access phase length in clocks
    localparam int PAL_WAIT  = 3;
    localparam int PAL_CNT_W = 2;           // wide enough for PAL_WAIT - 1

    // counter value one clock before pready
    localparam logic [PAL_CNT_W-1:0] PAL_LAST_CNT = PAL_CNT_W'(PAL_WAIT - 2);

endpackage

// File: source/video_pkg.sv
// video formats: pixel widths, layer enable bits, priority layer enum, palette index union
package video_pkg;

    // pixel index widths as they leave the tile and sprite engines
    localparam int CHAR_W = 7;
    localparam int OBJ_W  = 8;
    localparam int SCR_W  = 8;

    localparam int RGB_W      = 4;          // one colour channel
    localparam int LAYER_EN_W = 3;          // char, scroll, object
    localparam int EN_CHAR    = 0;
    localparam int EN_SCR     = 1;
    localparam int EN_OBJ     = 2;

    localparam int PRIO_AW = 8;             // 256 priority rules
    localparam int PRIO_DW = 2;             // one layer code per rule

    localparam int PAL_AW = 9;              // 512 entries per palette bank
    localparam int PAL_DW = 2 * RGB_W;      // green in the upper nibble, red below

    // winning layer as coded in the priority PROM
    typedef enum logic [PRIO_DW-1:0] {
        LAYER_CHAR     = 2'd0,
        LAYER_CHAR_ALT = 2'd1,              // same as char on the board
        LAYER_OBJ      = 2'd2,
        LAYER_SCR      = 2'd3
    } layer_e;

    // palette bank of each layer in the pixel view
    localparam logic [PAL_AW-CHAR_W-1:0] BANK_CHAR = 2'b00;
    localparam logic [PAL_AW-CHAR_W-1:0] BANK_OBJ  = 2'b01;
    localparam logic [PAL_AW-CHAR_W-1:0] BANK_SCR  = 2'b10;

    // palette address, cpu word index or layer bank plus colour
    typedef union packed {
        logic [PAL_AW-1:0] cpu;             // flat entry from the bus
        struct packed {
            logic [PAL_AW-CHAR_W-1:0] bank; // which layer owns the entry
            logic [CHAR_W-1:0]        color;
        } pxl;
    } pal_index_u;

endpackage
